//--- pitaya_params.svh
`ifndef PITAYA_PARAMS_SVH
`define PITAYA_PARAMS_SVH

// data path widths
`define PITAYA_ADC_RAW_W   14   // adc pin word
`define PITAYA_ADC_W       12   // working sample, two lsbs dropped
`define PITAYA_DAC_W       14   // dac pin word
`define PITAYA_PHASE_W     16   // sawtooth accumulator
`define PITAYA_GAIN_W      8    // signed controller gain
`define PITAYA_CTRL_SHIFT  4    // product scaling, arithmetic

// register bus
`define PITAYA_BUS_AW      8
`define PITAYA_BUS_DW      32

// byte addresses
`define PITAYA_ADDR_CTRL   8'h00  // bit 0 loop_en, bit 1 gen_en
`define PITAYA_ADDR_STEP_A 8'h04
`define PITAYA_ADDR_STEP_B 8'h08
`define PITAYA_ADDR_SET_A  8'h0C
`define PITAYA_ADDR_SET_B  8'h10
`define PITAYA_ADDR_GAIN_A 8'h14
`define PITAYA_ADDR_GAIN_B 8'h18
`define PITAYA_ADDR_ID     8'h1C  // read only

`define PITAYA_ID          32'h5049_5441

`endif

//--- pitaya_pkg.sv
`include "pitaya_params.svh"

package pitaya_pkg;

  //////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////

  typedef logic        [`PITAYA_ADC_RAW_W-1:0] adc_raw_t;   // as seen on adc pins
  typedef logic signed [`PITAYA_ADC_W-1:0]     adc_smp_t;   // after lsb drop
  typedef logic signed [`PITAYA_DAC_W-1:0]     dac_word_t;  // dac domain, also pins

  //////////////////////////////////////////////////
  // configuration types
  //////////////////////////////////////////////////

  typedef logic        [`PITAYA_PHASE_W-1:0]   phase_t;     // wraps mod 2^16
  typedef logic signed [`PITAYA_GAIN_W-1:0]    gain_t;

  // register bus
  typedef logic [`PITAYA_BUS_AW-1:0] bus_addr_t;
  typedef logic [`PITAYA_BUS_DW-1:0] bus_data_t;

endpackage

//--- pitaya_cfg_if.sv
`timescale 1ns/10ps

// configuration from the register block to generator and controller
interface pitaya_cfg_if import pitaya_pkg::*; ();

  logic     loop_en;          // digital loopback instead of adc
  logic     gen_en;           // sawtooth running
  phase_t   step_a, step_b;   // phase increments
  adc_smp_t set_a, set_b;     // controller setpoints
  gain_t    gain_a, gain_b;   // controller gains

  modport regs (
    output loop_en, gen_en,
    output step_a, step_b,
    output set_a, set_b,
    output gain_a, gain_b
  );

  modport gen (
    input gen_en, step_a, step_b
  );

  modport ctrl (
    input loop_en, set_a, set_b, gain_a, gain_b
  );

endinterface

//--- pitaya_regs.sv
`timescale 1ns/10ps
`include "pitaya_params.svh"

module pitaya_regs import pitaya_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  pitaya_cfg_if.regs cfg
);

  logic      addr_ok;  // one of the eight registers
  logic      wr_en;    // write to a writable register
  bus_data_t rd_mux;

  //////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////

  always_comb begin
    addr_ok = 1'b1;
    rd_mux  = '0;  // zero extension of short fields
    case (sys_addr_i)
      `PITAYA_ADDR_CTRL:   rd_mux[1:0] = {cfg.gen_en, cfg.loop_en};
      `PITAYA_ADDR_STEP_A: rd_mux[`PITAYA_PHASE_W-1:0] = cfg.step_a;
      `PITAYA_ADDR_STEP_B: rd_mux[`PITAYA_PHASE_W-1:0] = cfg.step_b;
      `PITAYA_ADDR_SET_A:  rd_mux[`PITAYA_ADC_W-1:0] = cfg.set_a;
      `PITAYA_ADDR_SET_B:  rd_mux[`PITAYA_ADC_W-1:0] = cfg.set_b;
      `PITAYA_ADDR_GAIN_A: rd_mux[`PITAYA_GAIN_W-1:0] = cfg.gain_a;
      `PITAYA_ADDR_GAIN_B: rd_mux[`PITAYA_GAIN_W-1:0] = cfg.gain_b;
      `PITAYA_ADDR_ID:     rd_mux = `PITAYA_ID;
      default:             addr_ok = 1'b0;  // unmapped
    endcase
  end

  assign wr_en = sys_wen_i && addr_ok && (sys_addr_i != `PITAYA_ADDR_ID);

  //////////////////////////////////////////////////
  // config registers, ack and error
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      cfg.loop_en <= 1'b0;
      cfg.gen_en  <= 1'b0;
      cfg.step_a  <= '0;
      cfg.step_b  <= '0;
      cfg.set_a   <= '0;
      cfg.set_b   <= '0;
      cfg.gain_a  <= '0;
      cfg.gain_b  <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // one cycle after the request
      sys_err_o <= (sys_ren_i & ~addr_ok) | (sys_wen_i & ~wr_en);
      if (wr_en) begin
        case (sys_addr_i)
          `PITAYA_ADDR_CTRL:   {cfg.gen_en, cfg.loop_en} <= sys_wdata_i[1:0];
          `PITAYA_ADDR_STEP_A: cfg.step_a <= sys_wdata_i[`PITAYA_PHASE_W-1:0];
          `PITAYA_ADDR_STEP_B: cfg.step_b <= sys_wdata_i[`PITAYA_PHASE_W-1:0];
          `PITAYA_ADDR_SET_A:  cfg.set_a  <= sys_wdata_i[`PITAYA_ADC_W-1:0];
          `PITAYA_ADDR_SET_B:  cfg.set_b  <= sys_wdata_i[`PITAYA_ADC_W-1:0];
          `PITAYA_ADDR_GAIN_A: cfg.gain_a <= sys_wdata_i[`PITAYA_GAIN_W-1:0];
          `PITAYA_ADDR_GAIN_B: cfg.gain_b <= sys_wdata_i[`PITAYA_GAIN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // read data, only meaningful with the ack of a read
  always_ff @(posedge adc_clk) begin
    sys_rdata_o <= sys_ren_i ? rd_mux : '0;
  end

endmodule

//--- sawtooth_gen.sv
`timescale 1ns/10ps
`include "pitaya_params.svh"

module sawtooth_gen import pitaya_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  pitaya_cfg_if.gen cfg,
  output dac_word_t gen_a_o,
  output dac_word_t gen_b_o
);

  phase_t phase_a;  // channel a accumulator
  phase_t phase_b;  // channel b accumulator

  //////////////////////////////////////////////////
  // phase accumulators and output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      phase_a <= '0;
      phase_b <= '0;
      gen_a_o <= '0;
      gen_b_o <= '0;
    end else if (!cfg.gen_en) begin
      // generator off, hold everything at zero
      phase_a <= '0;
      phase_b <= '0;
      gen_a_o <= '0;
      gen_b_o <= '0;
    end else begin
      phase_a <= phase_a + cfg.step_a;  // wraps mod 2^16
      phase_b <= phase_b + cfg.step_b;
      // top bits of the phase as a signed sample
      gen_a_o <= phase_a[`PITAYA_PHASE_W-1 -: `PITAYA_DAC_W];
      gen_b_o <= phase_b[`PITAYA_PHASE_W-1 -: `PITAYA_DAC_W];
    end
  end

endmodule

//--- prop_ctrl.sv
`timescale 1ns/10ps
`include "pitaya_params.svh"

module prop_ctrl import pitaya_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  adc_raw_t   adc_dat_a_i,
  input  adc_raw_t   adc_dat_b_i,
  input  dac_word_t  loop_a_i,     // coded dac words for loopback
  input  dac_word_t  loop_b_i,
  pitaya_cfg_if.ctrl cfg,
  output dac_word_t  ctrl_a_o,
  output dac_word_t  ctrl_b_o
);

  adc_smp_t                                      smp_a, smp_b;    // stage 1
  logic signed [`PITAYA_ADC_W:0]                 err_a, err_b;    // 13 bit error
  logic signed [`PITAYA_ADC_W+`PITAYA_GAIN_W:0]  prod_a, prod_b;  // stage 2
  logic signed [`PITAYA_ADC_W+`PITAYA_GAIN_W:0]  shr_a, shr_b;    // scaled product

  // clip the scaled product into the dac range
  function automatic dac_word_t sat_dac(input logic signed [`PITAYA_ADC_W+`PITAYA_GAIN_W:0] v);
    if (v > (2**(`PITAYA_DAC_W-1) - 1))
      return {1'b0, {(`PITAYA_DAC_W-1){1'b1}}};
    if (v < -(2**(`PITAYA_DAC_W-1)))
      return {1'b1, {(`PITAYA_DAC_W-1){1'b0}}};
    return v[`PITAYA_DAC_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // error and scaling
  //////////////////////////////////////////////////

  always_comb begin
    err_a = cfg.set_a - smp_a;  // sign extended to 13 bits
    err_b = cfg.set_b - smp_b;
    shr_a = prod_a >>> `PITAYA_CTRL_SHIFT;
    shr_b = prod_b >>> `PITAYA_CTRL_SHIFT;
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      smp_a    <= '0;
      smp_b    <= '0;
      prod_a   <= '0;
      prod_b   <= '0;
      ctrl_a_o <= '0;
      ctrl_b_o <= '0;
    end else begin
      // cross-over, adc b feeds channel a
      smp_a    <= cfg.loop_en ? loop_a_i[`PITAYA_DAC_W-1:2] : adc_dat_b_i[`PITAYA_ADC_RAW_W-1:2];
      smp_b    <= cfg.loop_en ? loop_b_i[`PITAYA_DAC_W-1:2] : adc_dat_a_i[`PITAYA_ADC_RAW_W-1:2];
      prod_a   <= err_a * cfg.gain_a;
      prod_b   <= err_b * cfg.gain_b;
      ctrl_a_o <= sat_dac(shr_a);  // stage 3
      ctrl_b_o <= sat_dac(shr_b);
    end
  end

endmodule

//--- dac_combiner.sv
`timescale 1ns/10ps
`include "pitaya_params.svh"

module dac_combiner import pitaya_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  dac_word_t gen_a_i,
  input  dac_word_t gen_b_i,
  input  dac_word_t ctrl_a_i,
  input  dac_word_t ctrl_b_i,
  output dac_word_t loop_a_o,
  output dac_word_t loop_b_o,
  output dac_word_t dac_dat_a_o,
  output dac_word_t dac_dat_b_o,
  output logic      dac_reset_o
);

  logic signed [`PITAYA_DAC_W:0] sum_a, sum_b;  // one bit headroom
  dac_word_t                     code_a, code_b; // inverted, per channel

  // saturate back to 14 bits when the two top bits differ
  function automatic dac_word_t sat_sum(input logic signed [`PITAYA_DAC_W:0] v);
    if (v[`PITAYA_DAC_W] != v[`PITAYA_DAC_W-1])
      return {v[`PITAYA_DAC_W], {(`PITAYA_DAC_W-1){~v[`PITAYA_DAC_W]}}};
    return v[`PITAYA_DAC_W-1:0];
  endfunction

  assign sum_a = gen_a_i + ctrl_a_i;
  assign sum_b = gen_b_i + ctrl_b_i;

  //////////////////////////////////////////////////
  // coding and pin register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      code_a      <= '1;  // coded zero
      code_b      <= '1;
      dac_dat_a_o <= '1;
      dac_dat_b_o <= '1;
    end else begin
      code_a      <= ~sat_sum(sum_a);  // negative slope dac
      code_b      <= ~sat_sum(sum_b);
      dac_dat_a_o <= code_b;  // ch b -> dac a
      dac_dat_b_o <= code_a;  // ch a -> dac b
    end
  end

  assign loop_a_o = code_a;
  assign loop_b_o = code_b;

  // dac held in reset until one edge after release
  always_ff @(posedge adc_clk) dac_reset_o <= ~rst_n_i;

endmodule

//--- pitaya_analog_top.sv
`timescale 1ns/10ps

module pitaya_analog_top import pitaya_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  // adc
  input  adc_raw_t  adc_dat_a_i,
  input  adc_raw_t  adc_dat_b_i,
  // register bus
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  // dac
  output dac_word_t dac_dat_a_o,
  output dac_word_t dac_dat_b_o,
  output logic      dac_reset_o
);

  dac_word_t gen_a, gen_b;    // sawtooth
  dac_word_t ctrl_a, ctrl_b;  // controller
  dac_word_t loop_a, loop_b;  // coded words back to the input

  pitaya_cfg_if cfg ();

  pitaya_regs i_regs (
    .adc_clk, .rst_n_i,
    .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_ack_o, .sys_err_o,
    .cfg      (cfg)
  );

  sawtooth_gen i_gen (
    .adc_clk, .rst_n_i,
    .cfg      (cfg),
    .gen_a_o  (gen_a),
    .gen_b_o  (gen_b)
  );

  prop_ctrl i_ctrl (
    .adc_clk, .rst_n_i,
    .adc_dat_a_i, .adc_dat_b_i,
    .loop_a_i (loop_a),
    .loop_b_i (loop_b),
    .cfg      (cfg),
    .ctrl_a_o (ctrl_a),
    .ctrl_b_o (ctrl_b)
  );

  dac_combiner i_dac (
    .adc_clk, .rst_n_i,
    .gen_a_i  (gen_a),  .gen_b_i  (gen_b),
    .ctrl_a_i (ctrl_a), .ctrl_b_i (ctrl_b),
    .loop_a_o (loop_a), .loop_b_o (loop_b),
    .dac_dat_a_o, .dac_dat_b_o, .dac_reset_o
  );

endmodule

//--- pitaya_properties.sv
`timescale 1ns/10ps

// bus handshake and dac reset rules on the top level
module pitaya_properties (
  input logic adc_clk,
  input logic rst_n_i,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic sys_ack_o,
  input logic sys_err_o,
  input logic dac_reset_o
);

  //////////////////////////////////////////////////
  // dac reset
  //////////////////////////////////////////////////

  dac_reset_follows: assert property (@(posedge adc_clk) !rst_n_i |=> dac_reset_o)
    else $error("dac_reset_o low one edge after rst_n_i was low");

  //////////////////////////////////////////////////
  // register bus
  //////////////////////////////////////////////////

  ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_o |=> !sys_ack_o) else $error("sys_ack_o high two cycles in a row");

  ack_after_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o) else $error("request without ack");

  err_with_ack: assert property (@(posedge adc_clk) sys_err_o |-> sys_ack_o)
    else $error("sys_err_o without sys_ack_o");  // error only with an ack

endmodule

//--- tb_pitaya.sv
`timescale 1ns/10ps
`include "pitaya_params.svh"

module tb_pitaya import pitaya_pkg::*; ();

  logic        adc_clk;
  logic        rst_n_i;
  adc_raw_t    adc_dat_a_i, adc_dat_b_i;
  bus_addr_t   sys_addr_i;
  bus_data_t   sys_wdata_i;
  logic        sys_wen_i, sys_ren_i;
  bus_data_t   sys_rdata_o;
  logic        sys_ack_o, sys_err_o;
  dac_word_t   dac_dat_a_o, dac_dat_b_o;
  logic        dac_reset_o;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] rng = 32'h87ea13c4;  // xorshift state
  bus_addr_t   cfg_addrs [7] = '{`PITAYA_ADDR_CTRL, `PITAYA_ADDR_STEP_A, `PITAYA_ADDR_STEP_B,
    `PITAYA_ADDR_SET_A, `PITAYA_ADDR_SET_B, `PITAYA_ADDR_GAIN_A, `PITAYA_ADDR_GAIN_B};

  pitaya_analog_top UUT (.*);

  bind pitaya_analog_top pitaya_properties i_props (
    .adc_clk, .rst_n_i, .sys_wen_i, .sys_ren_i, .sys_ack_o, .sys_err_o, .dac_reset_o
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns period
  end

  // hard limit on the whole run
  initial begin
    for (int c = 0; c < 20000; c++) @(posedge adc_clk);
    $display("run did not finish within 20000 cycles");
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // expected coded dac word of one channel with the generator off
  function automatic dac_word_t coded_ctrl(input adc_raw_t raw, input int set, input int gain);
    int smp;
    int v;
    smp = $signed(raw[`PITAYA_ADC_RAW_W-1:2]);  // two lsbs dropped
    v = ((set - smp) * gain) >>> `PITAYA_CTRL_SHIFT;
    if (v > 2**(`PITAYA_DAC_W-1) - 1)
      v = 2**(`PITAYA_DAC_W-1) - 1;
    if (v < -(2**(`PITAYA_DAC_W-1)))
      v = -(2**(`PITAYA_DAC_W-1));
    return ~dac_word_t'(v);  // negative slope
  endfunction

  // settled coded word of one channel fed by its own coded output
  function automatic dac_word_t loop_point(input int set, input int gain);
    dac_word_t code;
    code = '1;
    for (int i = 0; i < 64; i++)
      code = coded_ctrl(code, set, gain);  // coded word taken as the sample
    return code;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_dac(input string name, input dac_word_t got, input dac_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  //////////////////////////////////////////////////
  // bus and stimulus
  //////////////////////////////////////////////////

  task automatic bus_access(input bus_addr_t addr, input bus_data_t data, input logic write,
                            output bus_data_t rdata, output logic err);
    int n;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= write;
    sys_ren_i   <= !write;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;  // one-cycle request
    sys_ren_i <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < 16) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack_o) begin
      errors++;
      $display("bus access to address %h got no ack", addr);
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input logic exp_err = 0);
    bus_data_t rdata;
    logic      err;
    bus_access(addr, data, 1'b1, rdata, err);
    check_bit("sys_err_o", err, exp_err);
  endtask

  task automatic bus_read(input bus_addr_t addr, input bus_data_t exp, input logic exp_err = 0);
    bus_data_t rdata;
    logic      err;
    bus_access(addr, '0, 1'b0, rdata, err);
    check_bit("sys_err_o", err, exp_err);
    if (!exp_err)
      check_data("sys_rdata_o", rdata, exp);
  endtask

  task automatic drive_adc(input adc_raw_t a, input adc_raw_t b);
    @(posedge adc_clk);
    adc_dat_a_i <= a;
    adc_dat_b_i <= b;
  endtask

  // wait until both dac pins hold for eight cycles
  task automatic settle();
    dac_word_t a, b;
    int        stable, n;
    stable = 0;
    n = 0;
    @(negedge adc_clk);
    a = dac_dat_a_o;
    b = dac_dat_b_o;
    while (stable < 8 && n < 200) begin
      @(negedge adc_clk);
      stable = (dac_dat_a_o === a && dac_dat_b_o === b) ? stable + 1 : 0;
      a = dac_dat_a_o;
      b = dac_dat_b_o;
      n++;
    end
    if (stable < 8) begin
      errors++;
      $display("dac pins did not settle within 200 cycles");
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    int e0, i;
    e0 = errors;
    for (i = 0; i < 4; i++) begin
      @(posedge adc_clk);
      if (i == 3)
        rst_n_i <= 1'b1;  // release after the fourth edge
      @(negedge adc_clk);
      check_bit("dac_reset_o", dac_reset_o, 1'b1);
    end
    @(negedge adc_clk);
    check_bit("dac_reset_o", dac_reset_o, 1'b0);
    check_bit("sys_ack_o", sys_ack_o, 1'b0);
    check_bit("sys_err_o", sys_err_o, 1'b0);
    check_dac("dac_dat_a_o", dac_dat_a_o, 14'h3FFF);  // coded zero
    check_dac("dac_dat_b_o", dac_dat_b_o, 14'h3FFF);
    for (i = 0; i < 7; i++)
      bus_read(cfg_addrs[i], '0);
    report_test("reset state", e0);
  endtask

  task automatic register_bus();
    int e0;
    e0 = errors;
    bus_write(`PITAYA_ADDR_STEP_A, 32'hDEAD_1234);
    bus_write(`PITAYA_ADDR_STEP_B, 32'h0000_0040);
    bus_write(`PITAYA_ADDR_SET_A, 32'h0000_0ABC);
    bus_write(`PITAYA_ADDR_SET_B, 32'hFFFF_F123);
    bus_write(`PITAYA_ADDR_GAIN_A, 32'h0000_01A5);
    bus_write(`PITAYA_ADDR_GAIN_B, 32'h0000_007F);
    bus_write(`PITAYA_ADDR_CTRL, 32'h0000_0003);
    bus_read(`PITAYA_ADDR_CTRL, 32'h0000_0003);
    bus_write(`PITAYA_ADDR_CTRL, 32'hFFFF_FFFC);  // both enables clear again
    bus_read(`PITAYA_ADDR_CTRL, 32'h0);
    bus_read(`PITAYA_ADDR_STEP_A, 32'h0000_1234);  // zero extended
    bus_read(`PITAYA_ADDR_STEP_B, 32'h0000_0040);
    bus_read(`PITAYA_ADDR_SET_A, 32'h0000_0ABC);
    bus_read(`PITAYA_ADDR_SET_B, 32'h0000_0123);
    bus_read(`PITAYA_ADDR_GAIN_A, 32'h0000_00A5);
    bus_read(`PITAYA_ADDR_GAIN_B, 32'h0000_007F);
    bus_read(`PITAYA_ADDR_ID, `PITAYA_ID);
    bus_read(8'h20, '0, 1'b1);  // unmapped
    bus_write(8'h24, 32'h1, 1'b1);
    bus_write(`PITAYA_ADDR_ID, 32'h0, 1'b1);  // id is read only
    bus_read(`PITAYA_ADDR_ID, `PITAYA_ID);
    report_test("register bus", e0);
  endtask

  task automatic proportional_path();
    int e0, k;
    e0 = errors;
    bus_write(`PITAYA_ADDR_SET_A, 32'd300);
    bus_write(`PITAYA_ADDR_SET_B, 32'h0000_0E0C);  // -500
    bus_write(`PITAYA_ADDR_GAIN_A, 32'd5);
    bus_write(`PITAYA_ADDR_GAIN_B, 32'h0000_00FD);  // -3
    for (k = 0; k < 4; k++) begin
      rng = xorshift(rng);
      drive_adc(rng[13:0], rng[29:16]);
      settle();
      // pin a carries channel b fed by adc a
      check_dac("dac_dat_a_o", dac_dat_a_o, coded_ctrl(adc_dat_a_i, -500, -3));
      check_dac("dac_dat_b_o", dac_dat_b_o, coded_ctrl(adc_dat_b_i, 300, 5));
    end
    report_test("proportional path", e0);
  endtask

  task automatic saturation();
    int e0;
    e0 = errors;
    bus_write(`PITAYA_ADDR_GAIN_A, 32'h7F);
    bus_write(`PITAYA_ADDR_GAIN_B, 32'h7F);
    bus_write(`PITAYA_ADDR_SET_A, 32'h7FF);  // most positive setpoint
    bus_write(`PITAYA_ADDR_SET_B, 32'h800);  // most negative
    drive_adc(14'h1FFF, 14'h2000);
    settle();
    check_dac("dac_dat_a_o", dac_dat_a_o, 14'h1FFF);  // channel b at its negative limit
    check_dac("dac_dat_b_o", dac_dat_b_o, 14'h2000);
    report_test("saturation", e0);
  endtask

  task automatic generator();
    phase_t    step_a, step_b;
    dac_word_t prev_a, prev_b, cur_a, cur_b;
    int        e0, k;
    e0 = errors;
    step_a = 16'h0100;
    step_b = 16'h0044;
    bus_write(`PITAYA_ADDR_GAIN_A, 32'h0);
    bus_write(`PITAYA_ADDR_GAIN_B, 32'h0);
    bus_write(`PITAYA_ADDR_STEP_A, 32'(step_a));
    bus_write(`PITAYA_ADDR_STEP_B, 32'(step_b));
    bus_write(`PITAYA_ADDR_CTRL, 32'h2);  // generator on
    for (k = 0; k < 6; k++)
      @(negedge adc_clk);  // pipeline fill
    prev_a = ~dac_dat_a_o;
    prev_b = ~dac_dat_b_o;
    for (k = 0; k < 8; k++) begin
      @(negedge adc_clk);
      cur_a = ~dac_dat_a_o;
      cur_b = ~dac_dat_b_o;
      check_dac("dac_dat_a_o step", cur_a - prev_a, dac_word_t'(step_b >> 2));
      check_dac("dac_dat_b_o step", cur_b - prev_b, dac_word_t'(step_a >> 2));
      prev_a = cur_a;
      prev_b = cur_b;
    end
    report_test("generator", e0);
  endtask

  task automatic loopback();
    dac_word_t hold_a, hold_b;
    int        e0, k, j;
    e0 = errors;
    bus_write(`PITAYA_ADDR_GAIN_A, 32'd8);
    bus_write(`PITAYA_ADDR_GAIN_B, 32'd8);
    bus_write(`PITAYA_ADDR_SET_A, 32'd100);
    bus_write(`PITAYA_ADDR_SET_B, 32'h0000_0FC4);  // -60
    bus_write(`PITAYA_ADDR_CTRL, 32'h1);  // loop on and generator off
    settle();
    hold_a = loop_point(-60, 8);  // pin a carries channel b
    hold_b = loop_point(100, 8);
    check_dac("dac_dat_a_o", dac_dat_a_o, hold_a);
    check_dac("dac_dat_b_o", dac_dat_b_o, hold_b);
    for (k = 0; k < 4; k++) begin
      rng = xorshift(rng);
      drive_adc(rng[13:0], rng[29:16]);
      for (j = 0; j < 6; j++) begin
        @(negedge adc_clk);
        check_dac("dac_dat_a_o", dac_dat_a_o, hold_a);  // adc ignored
        check_dac("dac_dat_b_o", dac_dat_b_o, hold_b);
      end
    end
    report_test("loopback", e0);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    reset_state();
    register_bus();
    proportional_path();
    saturation();
    generator();
    loopback();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
pitaya_pkg.sv
pitaya_cfg_if.sv
pitaya_regs.sv
sawtooth_gen.sv
prop_ctrl.sv
dac_combiner.sv
pitaya_analog_top.sv
pitaya_properties.sv
tb_pitaya.sv

//--- Makefile
# verilator build and run of the analog path testbench
VERILATOR ?= verilator
TOP       ?= tb_pitaya
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# verdict comes from the log, not from the exit status
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
